// ==== flist.f ====
+incdir+logic
+incdir+bench
logic/nes_loader_pkg.sv
logic/ines_header_decode.sv
logic/game_loader.sv
logic/loader_write_sync.sv
logic/nes_loader_top.sv
bench/tb_nes_loader.sv

// ==== Bender.yml ====
package:
  name: nes_loader

sources:
  - include_dirs:
      - logic
    files:
      - logic/nes_loader_pkg.sv
      - logic/ines_header_decode.sv
      - logic/game_loader.sv
      - logic/loader_write_sync.sv
      - logic/nes_loader_top.sv
  - target: simulation
    include_dirs:
      - logic
      - bench
    files:
      - bench/tb_nes_loader.sv

// ==== bench/tb_nes_loader_checks.svh ====
// Reference models for image placement and the mapper descriptor
// Typed compare tasks for memory writes, mapper flags and status bits

`ifndef TB_NES_LOADER_CHECKS_SVH
`define TB_NES_LOADER_CHECKS_SVH

function automatic void expect_write(input int addr, input logic [7:0] data);
	mem_write_t w;
	w.addr = `NES_ADDR_W'(addr);
	w.data = data;
	exp_q.push_back(w);
endfunction

// Where every byte of the current image should land
function automatic void queue_expected_writes(input file_kind_t kind);
	int start;
	int raw_base;
	int prg_len;
	int chr_len;
	logic nes_img;
	logic fds_img;
	start = (kind == FILE_FDS) ? `FDS_BASE + 'h10 : 0;
	for (int i = 0; i < 16; i++)
		expect_write(start + i, image[i]);
	nes_img = image[0] == 8'h4E && image[1] == 8'h45 && image[2] == 8'h53 &&
		image[3] == 8'h1A && !image[6][2];
	fds_img = image[0] == 8'h46 && image[1] == 8'h44 && image[2] == 8'h53 &&
		image[3] == 8'h1A;
	prg_len = int'(image[4]) * 16384;  // 16 KiB pages
	chr_len = int'(image[5]) * 8192;   // 8 KiB pages
	raw_base = fds_img ? `FDS_BASE + 'h10 : (kind == FILE_BIOS) ? 'h10 : `FDS_BASE + 'h20;
	if (nes_img) begin
		for (int i = 0; i < prg_len; i++)
			expect_write(i, image[16 + i]);
		for (int i = 0; i < chr_len; i++)
			expect_write(`CHR_BASE + i, image[16 + prg_len + i]);
	end else if (fds_img || kind == FILE_BIOS || kind == FILE_FDS) begin
		for (int i = 16; i < image.size(); i++)
			expect_write(raw_base + i - 16, image[i]);
	end
endfunction

function automatic logic [2:0] page_code(input int pages);
	int code;
	code = 0;
	while (code < 7 && (1 << code) < pages)
		code++;
	return 3'(code);
endfunction

function automatic mapper_flags_t expected_flags(input logic raw_mode, input logic inv);
	logic [7:0] hdr [16];
	mapper_flags_t f;
	logic nes20;
	logic dirty;
	for (int i = 0; i < 16; i++)
		hdr[i] = image[i];
	if (raw_mode) begin
		// Fixed header that a finished raw image leaves behind
		hdr[4] = 8'hFF;
		hdr[5] = 8'h00;
		hdr[6] = 8'h40;
		hdr[7] = 8'h10;
		for (int i = 8; i < 16; i++)
			hdr[i] = 8'h00;
	end
	nes20 = hdr[7][3:2] == 2'b10;
	dirty = 1'b0;
	for (int i = 8; i < 16; i++)
		dirty = dirty | (hdr[i] != 8'h00);
	dirty = dirty && !nes20;
	f = '0;
	f.mapper = {dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
	f.prg_size = page_code(int'(hdr[4]));
	f.chr_size = page_code(int'(hdr[5]));
	f.mirroring = hdr[6][0] ^ inv;
	f.chr_ram = hdr[5] == 8'h00;
	f.four_screen = hdr[6][3];
	f.submapper = nes20 ? hdr[8] : 8'h00;
	return f;
endfunction

task automatic check_write(input string name, input mem_write_t exp, input mem_write_t act);
	if (act !== exp) begin
		$display("FAILED %s: expected addr %h data %h, actual addr %h data %h",
			name, exp.addr, exp.data, act.addr, act.data);
		fail_count++;
	end else
		pass_count++;
endtask

task automatic check_flags(input string name, input mapper_flags_t exp, input mapper_flags_t act);
	if (act !== exp) begin
		$display("FAILED %s: expected %h, actual %h", name, exp, act);
		fail_count++;
	end else
		pass_count++;
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("FAILED %s: expected %b, actual %b", name, exp, act);
		fail_count++;
	end else
		pass_count++;
endtask

`endif

// ==== bench/tb_nes_loader.sv ====
// Testbench for the cartridge loading path
// Clock, reset, image downloads, write monitor and compare, watchdog, summary

`include "nes_loader_config.svh"

module tb_nes_loader
	import nes_loader_pkg::*;
();

	localparam int RAW_LEN = 48;
	localparam int LOADS = 7;
	localparam int TOTAL_BYTES = (16 + 16384 + 8192) + 2 * 16 + 24 + 2 * (16 + RAW_LEN) + 16;
	localparam longint WATCHDOG_TIME =
		(longint'(TOTAL_BYTES) * 8 + LOADS * (`DL_RESET_CYCLES + 24) + 2000) * 100;

	logic          clk;
	logic          reset;
	logic          downloading;
	file_kind_t    file_kind;
	logic [7:0]    byte_data;
	logic          byte_wr;
	logic          invert_mirroring;
	mem_write_t    mem_wr;
	logic          mem_we;
	mapper_flags_t mapper_flags;
	logic          load_error;
	logic          nes_reset;

	logic [7:0] image [$];
	mem_write_t got_q [$];
	mem_write_t exp_q [$];
	string      cur_test;
	int         pass_count;
	int         fail_count;
	int         test_fail_base;
	logic       boot_reset;

	`include "tb_nes_loader_checks.svh"

	nes_loader_top u_dut (
		.clk              (clk),
		.reset            (reset),
		.downloading      (downloading),
		.file_kind        (file_kind),
		.byte_data        (byte_data),
		.byte_wr          (byte_wr),
		.invert_mirroring (invert_mirroring),
		.mem_wr           (mem_wr),
		.mem_we           (mem_we),
		.mapper_flags     (mapper_flags),
		.load_error       (load_error),
		.nes_reset        (nes_reset)
	);

	always #50 clk = ~clk;

	// Falling edge sees each full-cycle mem_we pulse once
	always @(negedge clk) begin
		if (mem_we)
			got_q.push_back(mem_wr);
	end

	always @(posedge clk) begin : compare_writes
		mem_write_t w;
		while (got_q.size() > 0) begin
			w = got_q.pop_front();
			if (exp_q.size() == 0)
				report_problem($sformatf("%s: write of %h to %h arrived but none was expected",
					cur_test, w.data, w.addr));
			else
				check_write(cur_test, exp_q.pop_front(), w);
		end
	end

	task automatic report_problem(input string msg);
		$display("%s", msg);
		fail_count++;
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_fail_base = fail_count;
	endtask

	task automatic end_test(input int num);
		if (fail_count == test_fail_base)
			$display("test %0d %s: ok", num, cur_test);
		else
			$display("test %0d %s: %0d check(s) failed", num, cur_test, fail_count - test_fail_base);
	endtask

	task automatic make_ines(input logic [7:0] prg, chr, b6, b7, b8, b12);
		image.delete();
		image = '{8'h4E, 8'h45, 8'h53, 8'h1A, prg, chr, b6, b7,
			b8, 8'h00, 8'h00, 8'h00, b12, 8'h00, 8'h00, 8'h00};
		repeat (int'(prg) * 16384 + int'(chr) * 8192)
			image.push_back(8'($urandom));
	endtask

	// First byte zero so no magic is ever matched
	task automatic make_raw(input int len);
		image.delete();
		image.push_back(8'h00);
		repeat (15 + len)
			image.push_back(8'($urandom));
	endtask

	task automatic send_image(input file_kind_t kind);
		file_kind = kind;
		downloading = 1'b1;
		repeat (8) @(negedge clk);
		foreach (image[i]) begin
			byte_data = image[i];
			byte_wr = 1'b1;
			@(negedge clk);
			byte_wr = 1'b0;
			repeat (7) @(negedge clk);  // One byte every 8 cycles
		end
		downloading = 1'b0;
	endtask

	task automatic wait_hold_end();
		repeat (`DL_RESET_CYCLES + 8) @(negedge clk);
	endtask

	task automatic check_writes_done();
		@(negedge clk);
		if (exp_q.size() != 0)
			report_problem($sformatf("%s: %0d expected writes never arrived",
				cur_test, exp_q.size()));
		exp_q.delete();
	endtask

	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog: the run did not finish within %0d time units", WATCHDOG_TIME);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		void'($urandom(62349));
		clk = 1'b0;
		reset = 1'b1;
		downloading = 1'b0;
		file_kind = FILE_ROM;
		byte_data = 8'h00;
		byte_wr = 1'b0;
		invert_mirroring = 1'b0;
		pass_count = 0;
		fail_count = 0;
		cur_test = "reset";
		repeat (16) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		boot_reset = nes_reset;  // Checked in the reset control test

		start_test("ines_basic");
		make_ines(8'd1, 8'd1, 8'h41, 8'h00, 8'h00, 8'h00);
		queue_expected_writes(FILE_ROM);
		send_image(FILE_ROM);
		wait_hold_end();
		check_writes_done();
		check_flags("ines_basic flags", expected_flags(1'b0, 1'b0), mapper_flags);
		end_test(1);

		start_test("header_rules");
		invert_mirroring = 1'b1;
		make_ines(8'd0, 8'd0, 8'h31, 8'h98, 8'h35, 8'h00);  // iNES 2.0 with submapper 0x35
		queue_expected_writes(FILE_ROM);
		send_image(FILE_ROM);
		wait_hold_end();
		check_writes_done();
		check_flags("header_rules nes20 flags", expected_flags(1'b0, 1'b1), mapper_flags);
		check_bit("header_rules nes20 mirroring", ~image[6][0], mapper_flags.mirroring);
		invert_mirroring = 1'b0;
		make_ines(8'd0, 8'd0, 8'h21, 8'hA0, 8'h00, 8'h44);  // Junk in byte 12
		queue_expected_writes(FILE_ROM);
		send_image(FILE_ROM);
		wait_hold_end();
		check_writes_done();
		check_flags("header_rules dirty flags", expected_flags(1'b0, 1'b0), mapper_flags);
		check_bit("header_rules dirty mirroring", image[6][0], mapper_flags.mirroring);
		end_test(2);

		start_test("bad_magic");
		make_raw(8);
		queue_expected_writes(FILE_ROM);
		send_image(FILE_ROM);
		@(negedge clk);
		check_bit("bad_magic load_error", 1'b1, load_error);
		check_bit("bad_magic nes_reset", 1'b1, nes_reset);
		wait_hold_end();
		check_writes_done();
		check_bit("bad_magic load_error after hold", 1'b1, load_error);
		check_bit("bad_magic nes_reset after hold", 1'b1, nes_reset);
		end_test(3);

		start_test("raw_images");
		make_raw(RAW_LEN);
		queue_expected_writes(FILE_BIOS);
		send_image(FILE_BIOS);
		wait_hold_end();
		check_writes_done();
		check_flags("raw_images bios flags", expected_flags(1'b1, 1'b0), mapper_flags);
		check_bit("raw_images bios load_error", 1'b0, load_error);
		make_raw(RAW_LEN);
		queue_expected_writes(FILE_FDS);
		send_image(FILE_FDS);
		wait_hold_end();
		check_writes_done();
		check_flags("raw_images fds flags", expected_flags(1'b1, 1'b0), mapper_flags);
		end_test(4);

		start_test("reset_control");
		check_bit("reset_control nes_reset before first download", 1'b1, boot_reset);
		make_ines(8'd0, 8'd0, 8'h00, 8'h00, 8'h00, 8'h00);
		queue_expected_writes(FILE_ROM);
		send_image(FILE_ROM);
		repeat (`DL_RESET_CYCLES - 1) @(negedge clk);
		check_bit("reset_control nes_reset 254 cycles after download", 1'b1, nes_reset);
		repeat (2) @(negedge clk);
		check_bit("reset_control nes_reset 256 cycles after download", 1'b0, nes_reset);
		check_writes_done();
		end_test(5);

		$display("%0d checks passed, %0d checks failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== logic/nes_loader_top.sv ====
// Cartridge loading path top level
// System reset control, mapper descriptor latch, loader and write sync

`include "nes_loader_config.svh"

module nes_loader_top
	import nes_loader_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          downloading,
	input  file_kind_t    file_kind,
	input  logic [7:0]    byte_data,
	input  logic          byte_wr,
	input  logic          invert_mirroring,
	output mem_write_t    mem_wr,
	output logic          mem_we,
	output mapper_flags_t mapper_flags,
	output logic          load_error,
	output logic          nes_reset
);

	logic          init_reset;
	logic [7:0]    dl_reset_cnt;
	logic          loader_reset;
	mem_write_t    loader_wr;
	logic          loader_wr_en;
	mapper_flags_t loader_flags;
	logic          loader_done;
	logic          loader_error;

	// Console stays in reset until the first image arrives
	always_ff @(posedge clk) begin
		if (reset)
			init_reset <= 1'b1;
		else if (downloading)
			init_reset <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (reset)
			dl_reset_cnt <= '0;
		else if (downloading)
			dl_reset_cnt <= 8'(`DL_RESET_CYCLES);
		else if (dl_reset_cnt != '0)
			dl_reset_cnt <= dl_reset_cnt - 1'b1;
	end

	// Loader re-arms once the post-download hold has run out
	assign loader_reset = reset || (dl_reset_cnt == '0);

	always_ff @(posedge clk) begin
		if (reset)
			mapper_flags <= '0;
		else if (loader_done)
			mapper_flags <= loader_flags;
	end

	assign load_error = loader_error && !init_reset;  // No load has happened yet
	assign nes_reset  = init_reset || downloading || (dl_reset_cnt != '0) || load_error;

	game_loader u_loader (
		.clk              (clk),
		.reset            (loader_reset),
		.downloading      (downloading),
		.file_kind        (file_kind),
		.byte_data        (byte_data),
		.byte_wr          (byte_wr),
		.invert_mirroring (invert_mirroring),
		.wr               (loader_wr),
		.wr_en            (loader_wr_en),
		.flags            (loader_flags),
		.done             (loader_done),
		.error            (loader_error)
	);

	loader_write_sync u_wr_sync (
		.clk    (clk),
		.reset  (reset),
		.wr_in  (loader_wr),
		.wr_en  (loader_wr_en),
		.wr_out (mem_wr),
		.we     (mem_we)
	);

endmodule

// ==== logic/loader_write_sync.sv ====
// Console clock-enable counter and one-deep write hold
// Releases each loader write in the next enable slot

`include "nes_loader_config.svh"

module loader_write_sync
	import nes_loader_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  mem_write_t wr_in,
	input  logic       wr_en,
	output mem_write_t wr_out,
	output logic       we
);

	localparam int CE_W = $clog2(`CE_DIV);

	logic [CE_W-1:0] ce_cnt;
	logic            ce_slot;
	logic            pending;
	mem_write_t      held;

	assign ce_slot = (ce_cnt == CE_W'(`CE_DIV - 1));

	// Free running, keeps counting through reset of the console
	always_ff @(posedge clk) begin
		if (reset)
			ce_cnt <= '0;
		else
			ce_cnt <= ce_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset)
			pending <= 1'b0;
		else if (wr_en)
			pending <= 1'b1;  // Newer byte wins over an unreleased one
		else if (ce_slot)
			pending <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			held <= wr_in;
	end

	assign we     = pending && ce_slot;
	assign wr_out = held;

endmodule

// ==== logic/game_loader.sv ====
// Download parser for iNES, BIOS and FDS images
// Captures the header and places each byte at its cartridge address

`include "nes_loader_config.svh"

module game_loader
	import nes_loader_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          downloading,
	input  file_kind_t    file_kind,
	input  logic [7:0]    byte_data,
	input  logic          byte_wr,
	input  logic          invert_mirroring,
	output mem_write_t    wr,
	output logic          wr_en,
	output mapper_flags_t flags,
	output logic          done,
	output logic          error
);

	localparam int CTR_W = $clog2(`HEADER_BYTES);

	loader_state_t          state;
	logic [CTR_W-1:0]       ctr;
	logic [7:0]             header [`HEADER_BYTES];
	logic [`NES_ADDR_W-1:0] addr;
	logic [`NES_ADDR_W-1:0] bytes_left;
	logic                   nes_magic;
	logic                   fds_magic;
	logic                   in_block;
	logic                   in_stream;

	// Bytes 0..14 are already registered when the last header byte arrives
	assign nes_magic = header[0] == 8'h4E && header[1] == 8'h45 &&
		header[2] == 8'h53 && header[3] == 8'h1A;
	assign fds_magic = header[0] == 8'h46 && header[1] == 8'h44 &&
		header[2] == 8'h53 && header[3] == 8'h1A;

	assign in_block  = (state == LD_PRG || state == LD_CHR) && bytes_left != '0;
	assign in_stream = downloading && (state == LD_HEADER || state == LD_RAW);
	assign wr_en     = byte_wr && (in_block || in_stream);
	assign wr        = '{addr: addr, data: byte_data};

	ines_header_decode u_decode (
		.header           (header),
		.invert_mirroring (invert_mirroring),
		.flags            (flags)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= LD_HEADER;
			ctr   <= '0;
			done  <= 1'b0;
			addr  <= (file_kind == FILE_FDS) ? `NES_ADDR_W'(`FDS_BASE + `HEADER_BYTES) : '0;
			if (downloading)
				error <= 1'b0;  // Cleared when a new download begins
		end else begin
			unique case (state)
				LD_HEADER: if (byte_wr && downloading) begin
					ctr         <= ctr + 1'b1;
					addr        <= addr + 1'b1;
					header[ctr] <= byte_data;
					bytes_left  <= `NES_ADDR_W'(header[4]) << `PRG_PAGE_SHIFT;
					if (ctr == CTR_W'(`HEADER_BYTES - 1)) begin
						if (nes_magic && !header[6][2]) begin  // Trainers unsupported
							state <= LD_PRG;
							addr  <= '0;
						end else if (fds_magic) begin
							state <= LD_RAW;
							addr  <= `NES_ADDR_W'(`FDS_BASE + `HEADER_BYTES);
						end else if (file_kind == FILE_BIOS) begin
							state <= LD_RAW;
							addr  <= `NES_ADDR_W'(`HEADER_BYTES);
						end else if (file_kind == FILE_FDS) begin
							state <= LD_RAW;
							addr  <= `NES_ADDR_W'(`FDS_BASE + 2 * `HEADER_BYTES);
						end else begin
							state <= LD_ERROR;
						end
					end
				end
				LD_PRG, LD_CHR: begin
					if (bytes_left != '0) begin
						if (byte_wr) begin
							bytes_left <= bytes_left - 1'b1;
							addr       <= addr + 1'b1;
						end
					end else if (state == LD_PRG) begin
						state      <= LD_CHR;
						addr       <= `CHR_BASE;
						bytes_left <= `NES_ADDR_W'(header[5]) << `CHR_PAGE_SHIFT;
					end else begin
						done <= 1'b1;
					end
				end
				LD_ERROR: begin
					done  <= 1'b1;
					error <= 1'b1;
				end
				LD_RAW: begin
					if (downloading) begin
						if (byte_wr)
							addr <= addr + 1'b1;
					end else begin
						// Synthetic header for mapper 20 with CHR RAM and the full PRG window
						done      <= 1'b1;
						header[4] <= 8'hFF;
						header[5] <= 8'h00;
						header[6] <= 8'h40;
						header[7] <= 8'h10;
						for (int i = 8; i < `HEADER_BYTES; i++) begin
							header[i] <= 8'h00;
						end
					end
				end
				default: state <= LD_HEADER;
			endcase
		end
	end

endmodule

// ==== logic/ines_header_decode.sv ====
// Combinational iNES header decode into the packed mapper descriptor
// Handles iNES 2.0 detection, dirty 1.0 headers and mirroring inversion

`include "nes_loader_config.svh"

module ines_header_decode
	import nes_loader_pkg::*;
(
	input  logic [7:0]    header [`HEADER_BYTES],
	input  logic          invert_mirroring,
	output mapper_flags_t flags
);

	logic [7:0] prg_pages;
	logic [7:0] chr_pages;
	logic       is_nes20;
	logic       upper_nonzero;
	logic       is_dirty;

	// Smallest power of two that holds the page count, capped at code 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if (pages <= (8'd1 << i))
				code = 3'(i);
		end
		return code;
	endfunction

	assign prg_pages = header[4];
	assign chr_pages = header[5];
	assign is_nes20  = (header[7][3:2] == 2'b10);

	// Junk left in bytes 8..15 by old dumping tools
	always_comb begin
		upper_nonzero = 1'b0;
		for (int i = 8; i < `HEADER_BYTES; i++) begin
			upper_nonzero = upper_nonzero | (header[i] != 8'h00);
		end
	end

	assign is_dirty = !is_nes20 && upper_nonzero;

	always_comb begin
		flags             = '0;
		flags.mapper[3:0] = header[6][7:4];
		flags.mapper[7:4] = is_dirty ? 4'h0 : header[7][7:4];  // Upper nibble untrusted
		flags.prg_size    = size_code(prg_pages);
		flags.chr_size    = size_code(chr_pages);
		flags.mirroring   = header[6][0] ^ invert_mirroring;
		flags.chr_ram     = (chr_pages == 8'h00);
		flags.four_screen = header[6][3];
		flags.submapper   = is_nes20 ? header[8] : 8'h00;
	end

endmodule

// ==== logic/nes_loader_pkg.sv ====
// Shared loader types
// File kinds from the host, loader FSM states, mapper descriptor, memory write

package nes_loader_pkg;

	`include "nes_loader_config.svh"

	// Host download index
	typedef enum logic [7:0] {
		FILE_ROM  = 8'd0,
		FILE_BIOS = 8'd2,
		FILE_FDS  = 8'd3
	} file_kind_t;

	typedef enum logic [2:0] {
		LD_HEADER,  // Collecting the 16 header bytes
		LD_PRG,     // Counted PRG block
		LD_CHR,     // Counted CHR block
		LD_ERROR,   // Unrecognised image
		LD_RAW      // Contiguous copy until download ends
	} loader_state_t;

	// Descriptor handed to the mapper logic of the console
	typedef struct packed {
		logic [6:0] pad;
		logic [7:0] submapper;    // iNES 2.0 byte 8
		logic       four_screen;
		logic       chr_ram;
		logic       mirroring;    // 1 = vertical
		logic [2:0] chr_size;     // log2 of 8 KiB pages, rounded up
		logic [2:0] prg_size;     // log2 of 16 KiB pages, rounded up
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef struct packed {
		logic [`NES_ADDR_W-1:0] addr;
		logic [7:0]             data;
	} mem_write_t;

endpackage

// ==== logic/nes_loader_config.svh ====
// Build-time constants for the cartridge loader
// Address width, memory bases, page shifts, clock-enable divider, reset hold

`ifndef NES_LOADER_CONFIG_SVH
`define NES_LOADER_CONFIG_SVH

// Cartridge memory is 4 MiB of bytes
`define NES_ADDR_W 22

// CHR sits in the top half, PRG starts at zero
`define CHR_BASE 22'h200000

// Disk images live above the BIOS region
`define FDS_BASE 22'h010000

// iNES / FDS header length in bytes
`define HEADER_BYTES 16

// PRG pages are 16 KiB, CHR pages 8 KiB
`define PRG_PAGE_SHIFT 14
`define CHR_PAGE_SHIFT 13

// Console runs on every fourth clock
`define CE_DIV 4

// Cycles the console stays in reset after a download ends
`define DL_RESET_CYCLES 255

`endif
